/* dv/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// random source
// ~~~~~~~~~~~~~~~~~~~~

// 32-bit fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h5bfe_d2b0;

// one lfsr step per returned bit
function automatic logic [31:0] next_rand_bits(input int count);
    logic [31:0] result;
    logic feedback;
    result = '0;
    for (int i = 0; i < count; i++)
    begin
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        result = {result[30:0], feedback};
    end
    return result;
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~

// raw samples of the projection being filled
logic signed [nabp_pkg::k_sample_length-1:0] sent_samples [nabp_pkg::k_s_count];

// expected line per role, ok flag marks known content
logic signed [nabp_pkg::k_filtered_length-1:0] fill_line [nabp_pkg::k_s_count];
logic signed [nabp_pkg::k_filtered_length-1:0] pr0_line [nabp_pkg::k_s_count];
logic signed [nabp_pkg::k_filtered_length-1:0] pr1_line [nabp_pkg::k_s_count];
logic fill_ok = 1'b0;
logic pr0_ok = 1'b0;
logic pr1_ok = 1'b0;

// expected angle shift registers
logic [nabp_pkg::k_angle_length-1:0] m_pr0_angle = '0;
logic [nabp_pkg::k_angle_length-1:0] m_pr1_angle = '0;
logic m_pr0_valid = 1'b0;
logic m_pr1_valid = 1'b0;

// high-pass filter of one projection, zero history at its start
function automatic void filter_projection();
    int oldest;
    int middle;
    int sum;
    for (int i = 0; i < nabp_pkg::k_s_count; i++)
    begin
        middle = (i >= 1) ? int'(sent_samples[i-1]) : 0;
        oldest = (i >= 2) ? int'(sent_samples[i-2]) : 0;
        sum = nabp_pkg::k_fir_tap_0 * oldest + nabp_pkg::k_fir_tap_1 * middle
            + nabp_pkg::k_fir_tap_2 * int'(sent_samples[i]);
        fill_line[i] = sum[nabp_pkg::k_filtered_length-1:0];
    end
    fill_ok = 1'b1;
endfunction

// fill -> pr0 -> pr1, angles and valid flags shift along
function automatic void rotate_roles(input logic [7:0] angle, input logic has_next);
    pr1_line = pr0_line;
    pr1_ok = pr0_ok;
    pr0_line = fill_line;
    pr0_ok = fill_ok;
    fill_ok = 1'b0;
    m_pr1_angle = m_pr0_angle;
    m_pr0_angle = angle;
    m_pr1_valid = m_pr0_valid;
    m_pr0_valid = has_next;
endfunction

`endif

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    logic clk = 1'b0;
    logic reset_n;
    logic [nabp_pkg::k_angle_length-1:0] hs_angle;
    logic hs_has_next_angle;
    logic hs_next_angle_ack;
    logic signed [nabp_pkg::k_sample_length-1:0] hs_sample;
    logic hs_sample_valid;
    logic hs_next_angle;
    logic [nabp_pkg::k_s_length-1:0] pr0_s_val;
    logic [nabp_pkg::k_s_length-1:0] pr1_s_val;
    logic pr_next_angle;
    logic pr_done;
    logic pr_next_angle_ack;
    logic [nabp_pkg::k_angle_length-1:0] pr0_angle;
    logic [nabp_pkg::k_angle_length-1:0] pr1_angle;
    logic pr0_next_angle_valid;
    logic pr1_next_angle_valid;
    logic signed [nabp_pkg::k_filtered_length-1:0] pr0_val;
    logic signed [nabp_pkg::k_filtered_length-1:0] pr1_val;

    int error_count = 0;
    int check_count = 0;
    // samples since the last host ack, gates the request
    int samples_since_ack = 0;
    int limit_cycles = 0;
    int first_run;
    int second_run;

    `include "tb_model.svh"

    nabp_filter_stage dut_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .hs_angle(hs_angle),
        .hs_has_next_angle(hs_has_next_angle),
        .hs_next_angle_ack(hs_next_angle_ack),
        .hs_sample(hs_sample),
        .hs_sample_valid(hs_sample_valid),
        .hs_next_angle(hs_next_angle),
        .pr0_s_val(pr0_s_val),
        .pr1_s_val(pr1_s_val),
        .pr_next_angle(pr_next_angle),
        .pr_done(pr_done),
        .pr_next_angle_ack(pr_next_angle_ack),
        .pr0_angle(pr0_angle),
        .pr1_angle(pr1_angle),
        .pr0_next_angle_valid(pr0_next_angle_valid),
        .pr1_next_angle_valid(pr1_next_angle_valid),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic check_value(input string name, input int expected, input int observed);
        check_count++;
        assert (expected == observed)
        else
        begin
            error_count++;
            $display("[FAIL] %0t ns %s expected %0d observed %0d",
                     $time, name, expected, observed);
        end
    endtask

    // valid flags every rotation, angles only where valid
    task automatic check_roles();
        check_value("pr0_next_angle_valid", m_pr0_valid, pr0_next_angle_valid);
        check_value("pr1_next_angle_valid", m_pr1_valid, pr1_next_angle_valid);
        if (m_pr0_valid)
        begin
            check_value("pr0_angle", m_pr0_angle, pr0_angle);
        end
        if (m_pr1_valid)
        begin
            check_value("pr1_angle", m_pr1_angle, pr1_angle);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // request gating
    // ~~~~~~~~~~~~~~~~~~~~

    // no request before a full line since the last ack
    always @(negedge clk)
    begin
        #1;
        if (!reset_n && samples_since_ack < nabp_pkg::k_s_count)
        begin
            check_value("hs_next_angle", 0, hs_next_angle);
        end
    end

    // 16 strobes back to back
    task automatic send_samples();
        for (int i = 0; i < nabp_pkg::k_s_count; i++)
        begin
            @(negedge clk);
            hs_sample = next_rand_bits(nabp_pkg::k_sample_length);
            hs_sample_valid = 1'b1;
            sent_samples[i] = hs_sample;
            samples_since_ack++;
        end
        @(negedge clk);
        hs_sample_valid = 1'b0;
        filter_projection();
    endtask

    // pr0 walks up, pr1 walks down, data one cycle behind address
    task automatic read_lines();
        logic [nabp_pkg::k_s_length-1:0] addr0;
        logic [nabp_pkg::k_s_length-1:0] addr1;
        for (int i = 0; i <= nabp_pkg::k_s_count; i++)
        begin
            @(negedge clk);
            if (i > 0)
            begin
                if (pr0_ok)
                begin
                    check_value("pr0_val", pr0_line[addr0], pr0_val);
                end
                if (pr1_ok)
                begin
                    check_value("pr1_val", pr1_line[addr1], pr1_val);
                end
            end
            addr0 = nabp_pkg::k_s_length'(i);
            addr1 = ~nabp_pkg::k_s_length'(i);
            pr0_s_val = addr0;
            pr1_s_val = addr1;
        end
    endtask

    // host ack of a new angle, first one of a run needs no request
    task automatic host_rotate(input logic first);
        logic [nabp_pkg::k_angle_length-1:0] angle;
        int delay;
        angle = next_rand_bits(nabp_pkg::k_angle_length);
        delay = next_rand_bits(2);
        @(negedge clk);
        pr_next_angle = !first;
        if (!first)
        begin
            #1;
            while (!hs_next_angle)
            begin
                @(negedge clk);
                #1;
            end
        end
        repeat (delay) @(negedge clk);
        @(negedge clk);
        hs_has_next_angle = 1'b1;
        hs_next_angle_ack = 1'b1;
        #1;
        check_value("pr_next_angle_ack", !first, pr_next_angle_ack);
        @(negedge clk);
        hs_next_angle_ack = 1'b0;
        pr_next_angle = 1'b0;
        // angle of the filled line moves into pr0 with its data
        rotate_roles(hs_angle, 1'b1);
        // host now sends the accepted projection under its angle
        hs_angle = angle;
        samples_since_ack = 0;
        check_roles();
    endtask

    // processing request with no angles left, no host ack
    task automatic drain_rotate();
        @(negedge clk);
        hs_has_next_angle = 1'b0;
        pr_next_angle = 1'b1;
        #1;
        while (!pr_next_angle_ack)
        begin
            @(negedge clk);
            #1;
        end
        check_value("hs_next_angle", 0, hs_next_angle);
        @(negedge clk);
        pr_next_angle = 1'b0;
        rotate_roles(hs_angle, 1'b0);
        check_roles();
    endtask

    task automatic run_projections(input int count);
        for (int k = 0; k < count; k++)
        begin
            host_rotate(k == 0);
            read_lines();
            send_samples();
        end
        // last line into pr0, then into pr1
        drain_rotate();
        read_lines();
        drain_rotate();
        read_lines();
        @(negedge clk);
        pr_done = 1'b1;
        @(negedge clk);
        pr_done = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // watchdog
    // ~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped responding", limit_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        reset_n = 1'b1;
        hs_angle = '0;
        hs_has_next_angle = 1'b0;
        hs_next_angle_ack = 1'b0;
        hs_sample = '0;
        hs_sample_valid = 1'b0;
        pr0_s_val = '0;
        pr1_s_val = '0;
        pr_next_angle = 1'b0;
        pr_done = 1'b0;
        first_run = 6 + next_rand_bits(2);
        second_run = 2 + next_rand_bits(1);
        limit_cycles = (first_run + second_run) * 60 + 200;
        repeat (4) @(negedge clk);
        reset_n = 1'b0;
        // idle after reset, nothing requested or valid
        repeat (3)
        begin
            @(negedge clk);
            #1;
            check_value("pr_next_angle_ack", 0, pr_next_angle_ack);
            check_value("pr0_next_angle_valid", 0, pr0_next_angle_valid);
            check_value("pr1_next_angle_valid", 0, pr1_next_angle_valid);
        end
        run_projections(first_run);
        // restart from ready after pr_done
        run_projections(second_run);
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f tb.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0

/* source/filtered_ram_swap_control.sv */
`timescale 1ns/1ps

module filtered_ram_swap_control
(
    // global signals
    input  logic clk,
    input  logic reset_n,
    // host side
    input  logic [nabp_pkg::k_angle_length-1:0] hs_angle,
    input  logic hs_has_next_angle,
    input  logic hs_next_angle_ack,
    output logic hs_next_angle,
    // from filter
    input  logic signed [nabp_pkg::k_filtered_length-1:0] filtered_val,
    input  logic filtered_valid,
    // processing side
    input  logic [nabp_pkg::k_s_length-1:0] pr0_s_val,
    input  logic [nabp_pkg::k_s_length-1:0] pr1_s_val,
    input  logic pr_next_angle,
    input  logic pr_done,
    output logic pr_next_angle_ack,
    output logic [nabp_pkg::k_angle_length-1:0] pr0_angle,
    output logic [nabp_pkg::k_angle_length-1:0] pr1_angle,
    output logic pr0_next_angle_valid,
    output logic pr1_next_angle_valid,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr0_val,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr1_val
);

    typedef logic [nabp_pkg::k_rotate_length-1:0] rot_t;
    typedef logic [nabp_pkg::k_state_length-1:0] state_t;
    typedef logic signed [nabp_pkg::k_filtered_length-1:0] fval_t;

    localparam rot_t k_last_sel = rot_t'(nabp_pkg::k_rotate - 1);

    state_t state;
    state_t next_state;
    rot_t rotate_sel;
    logic rotate;

    // buffer currently in each role
    rot_t fill_idx;
    rot_t pr0_idx;
    rot_t pr1_idx;

    // per swappable signals
    logic [nabp_pkg::k_rotate-1:0] sw_fill_kick;
    logic [nabp_pkg::k_rotate-1:0] sw_fill_valid;
    logic [nabp_pkg::k_rotate-1:0] sw_fill_done;
    fval_t sw_rd0_val [nabp_pkg::k_rotate];
    fval_t sw_rd1_val [nabp_pkg::k_rotate];

    // fill status of the buffer in fill role
    logic fill_done;

    // ~~~~~~~~~~~~~~~~~~~~
    // role mapping
    // ~~~~~~~~~~~~~~~~~~~~

    // sel 0: fill 0, pr0 1, pr1 2
    // sel 1: fill 2, pr0 0, pr1 1
    // sel 2: fill 1, pr0 2, pr1 0
    always_comb
    begin
        case (rotate_sel)
            2'd0:
            begin
                fill_idx = 2'd0;
                pr0_idx = 2'd1;
                pr1_idx = 2'd2;
            end
            2'd1:
            begin
                fill_idx = 2'd2;
                pr0_idx = 2'd0;
                pr1_idx = 2'd1;
            end
            default:
            begin
                fill_idx = 2'd1;
                pr0_idx = 2'd2;
                pr1_idx = 2'd0;
            end
        endcase
    end

    // steer fill strobes and kick, pick read data
    always_comb
    begin
        sw_fill_valid = '0;
        sw_fill_valid[fill_idx] = filtered_valid;
        // pr1 buffer becomes the fill buffer after rotate
        sw_fill_kick = '0;
        sw_fill_kick[pr1_idx] = rotate;
    end

    assign fill_done = sw_fill_done[fill_idx];
    assign pr0_val = sw_rd0_val[pr0_idx];
    assign pr1_val = sw_rd1_val[pr1_idx];

    // ~~~~~~~~~~~~~~~~~~~~
    // rotate decision
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        rotate = 1'b0;
        hs_next_angle = 1'b0;
        pr_next_angle_ack = 1'b0;
        case (state)
            nabp_pkg::k_state_ready:
            begin
                // host restarts filling on its own
                rotate = hs_next_angle_ack;
            end
            nabp_pkg::k_state_fill:
            begin
                if (fill_done)
                begin
                    hs_next_angle = hs_has_next_angle;
                    // no host ack needed once angles run out
                    if (hs_next_angle_ack || !hs_has_next_angle)
                    begin
                        rotate = 1'b1;
                        pr_next_angle_ack = 1'b1;
                    end
                end
            end
            nabp_pkg::k_state_fill_and_work_1, nabp_pkg::k_state_fill_and_work_2:
            begin
                // both a full line and a waiting processor
                if (fill_done && pr_next_angle)
                begin
                    hs_next_angle = hs_has_next_angle;
                    if (hs_next_angle_ack || !hs_has_next_angle)
                    begin
                        rotate = 1'b1;
                        pr_next_angle_ack = 1'b1;
                    end
                end
            end
            nabp_pkg::k_state_work_1:
            begin
                // drain, last line shifts into pr1
                rotate = pr_next_angle;
                pr_next_angle_ack = pr_next_angle;
            end
            default:
            begin
                // work_2 only waits for pr_done
                rotate = 1'b0;
            end
        endcase
    end

    // next state
    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::k_state_ready:
                if (rotate)
                    next_state = nabp_pkg::k_state_fill;
            nabp_pkg::k_state_fill:
                if (rotate)
                    next_state = hs_has_next_angle ? nabp_pkg::k_state_fill_and_work_1
                                                   : nabp_pkg::k_state_work_1;
            nabp_pkg::k_state_fill_and_work_1, nabp_pkg::k_state_fill_and_work_2:
                if (rotate)
                    next_state = hs_has_next_angle ? nabp_pkg::k_state_fill_and_work_2
                                                   : nabp_pkg::k_state_work_1;
            nabp_pkg::k_state_work_1:
                if (rotate)
                    next_state = nabp_pkg::k_state_work_2;
            nabp_pkg::k_state_work_2:
                if (pr_done)
                    next_state = nabp_pkg::k_state_ready;
            default:
                next_state = nabp_pkg::k_state_ready;
        endcase
    end

    // state and select registers
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= nabp_pkg::k_state_ready;
            rotate_sel <= '0;
            pr0_next_angle_valid <= 1'b0;
            pr1_next_angle_valid <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (rotate)
            begin
                // wrap after last buffer
                rotate_sel <= (rotate_sel == k_last_sel) ? '0 : rotate_sel + 1'b1;
                pr0_next_angle_valid <= hs_has_next_angle;
                pr1_next_angle_valid <= pr0_next_angle_valid;
            end
        end
    end

    // angles move with the data
    always_ff @(posedge clk)
    begin
        if (rotate)
        begin
            pr0_angle <= hs_angle;
            pr1_angle <= pr0_angle;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // line buffers
    // ~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < nabp_pkg::k_rotate; i++)
    begin : sw_gen
        // port 0 serves pr0, port 1 serves pr1
        filtered_ram_swappable swappable_i
        (
            .clk(clk),
            .reset_n(reset_n),
            .fill_kick(sw_fill_kick[i]),
            .fill_val(filtered_val),
            .fill_valid(sw_fill_valid[i]),
            .rd0_s_val(pr0_s_val),
            .rd1_s_val(pr1_s_val),
            .fill_done(sw_fill_done[i]),
            .rd0_val(sw_rd0_val[i]),
            .rd1_val(sw_rd1_val[i])
        );
    end

endmodule

/* source/filtered_ram_swappable.sv */
`timescale 1ns/1ps

module filtered_ram_swappable
(
    // global signals
    input  logic clk,
    input  logic reset_n,
    // fill side
    input  logic fill_kick,
    input  logic signed [nabp_pkg::k_filtered_length-1:0] fill_val,
    input  logic fill_valid,
    // read side, two independent addresses
    input  logic [nabp_pkg::k_s_length-1:0] rd0_s_val,
    input  logic [nabp_pkg::k_s_length-1:0] rd1_s_val,
    // fill status
    output logic fill_done,
    // read data, one cycle after address
    output logic signed [nabp_pkg::k_filtered_length-1:0] rd0_val,
    output logic signed [nabp_pkg::k_filtered_length-1:0] rd1_val
);

    typedef logic [nabp_pkg::k_s_length-1:0] addr_t;
    typedef logic signed [nabp_pkg::k_filtered_length-1:0] fval_t;

    // last address of a projection
    localparam addr_t k_last_addr = addr_t'(nabp_pkg::k_s_count - 1);

    // line storage
    fval_t mem [nabp_pkg::k_s_count];

    // write pointer, counts filtered strobes since kick
    addr_t wr_ptr;
    logic wr_en;

    // extra strobes past a full line are dropped
    assign wr_en = fill_valid && !fill_done;

    // ~~~~~~~~~~~~~~~~~~~~
    // fill control
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            wr_ptr <= '0;
            fill_done <= 1'b0;
        end
        else if (fill_kick)
        begin
            // restart at first sample
            wr_ptr <= '0;
            fill_done <= 1'b0;
        end
        else if (wr_en)
        begin
            wr_ptr <= wr_ptr + 1'b1;
            // set on the edge writing the last sample
            if (wr_ptr == k_last_addr)
            begin
                fill_done <= 1'b1;
            end
        end
    end

    // memory write
    always_ff @(posedge clk)
    begin
        if (wr_en && !fill_kick)
        begin
            mem[wr_ptr] <= fill_val;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read ports
    // ~~~~~~~~~~~~~~~~~~~~

    // registered, fixed latency of one
    always_ff @(posedge clk)
    begin
        rd0_val <= mem[rd0_s_val];
        rd1_val <= mem[rd1_s_val];
    end

endmodule

/* source/nabp_filter_stage.sv */
`timescale 1ns/1ps

module nabp_filter_stage
(
    // global signals
    input  logic clk,
    input  logic reset_n,
    // host side
    input  logic [nabp_pkg::k_angle_length-1:0] hs_angle,
    input  logic hs_has_next_angle,
    input  logic hs_next_angle_ack,
    input  logic signed [nabp_pkg::k_sample_length-1:0] hs_sample,
    input  logic hs_sample_valid,
    output logic hs_next_angle,
    // processing side
    input  logic [nabp_pkg::k_s_length-1:0] pr0_s_val,
    input  logic [nabp_pkg::k_s_length-1:0] pr1_s_val,
    input  logic pr_next_angle,
    input  logic pr_done,
    output logic pr_next_angle_ack,
    output logic [nabp_pkg::k_angle_length-1:0] pr0_angle,
    output logic [nabp_pkg::k_angle_length-1:0] pr1_angle,
    output logic pr0_next_angle_valid,
    output logic pr1_next_angle_valid,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr0_val,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr1_val
);

    // filter to swap control
    logic signed [nabp_pkg::k_filtered_length-1:0] filtered_val;
    logic filtered_valid;

    // history cleared on each host ack
    projection_fir fir_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .angle_start(hs_next_angle_ack),
        .hs_sample(hs_sample),
        .hs_sample_valid(hs_sample_valid),
        .filtered_val(filtered_val),
        .filtered_valid(filtered_valid)
    );

    filtered_ram_swap_control swap_control_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .hs_angle(hs_angle),
        .hs_has_next_angle(hs_has_next_angle),
        .hs_next_angle_ack(hs_next_angle_ack),
        .hs_next_angle(hs_next_angle),
        .filtered_val(filtered_val),
        .filtered_valid(filtered_valid),
        .pr0_s_val(pr0_s_val),
        .pr1_s_val(pr1_s_val),
        .pr_next_angle(pr_next_angle),
        .pr_done(pr_done),
        .pr_next_angle_ack(pr_next_angle_ack),
        .pr0_angle(pr0_angle),
        .pr1_angle(pr1_angle),
        .pr0_next_angle_valid(pr0_next_angle_valid),
        .pr1_next_angle_valid(pr1_next_angle_valid),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val)
    );

endmodule

/* source/nabp_pkg.sv */
package nabp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // data widths
    // ~~~~~~~~~~~~~~~~~~~~

    // projection angle
    localparam int k_angle_length = 8;
    // raw host sample, signed
    localparam int k_sample_length = 12;
    // filtered sample, signed, room for tap gain of 4
    localparam int k_filtered_length = 14;

    // samples per projection and their address width
    localparam int k_s_count = 16;
    localparam int k_s_length = 4;

    // ~~~~~~~~~~~~~~~~~~~~
    // high-pass filter taps
    // ~~~~~~~~~~~~~~~~~~~~

    // oldest sample
    localparam int k_fir_tap_0 = -1;
    // middle sample
    localparam int k_fir_tap_1 = 2;
    // newest sample
    localparam int k_fir_tap_2 = -1;

    // ~~~~~~~~~~~~~~~~~~~~
    // swap control
    // ~~~~~~~~~~~~~~~~~~~~

    // number of swappable line buffers
    localparam int k_rotate = 3;
    localparam int k_rotate_length = 2;

    // controller state encoding
    localparam int k_state_length = 3;
    localparam logic [k_state_length-1:0] k_state_ready = 3'd0;
    localparam logic [k_state_length-1:0] k_state_fill = 3'd1;
    localparam logic [k_state_length-1:0] k_state_fill_and_work_1 = 3'd2;
    localparam logic [k_state_length-1:0] k_state_fill_and_work_2 = 3'd3;
    localparam logic [k_state_length-1:0] k_state_work_1 = 3'd4;
    localparam logic [k_state_length-1:0] k_state_work_2 = 3'd5;

endpackage

/* source/projection_fir.sv */
`timescale 1ns/1ps

module projection_fir
(
    // global signals
    input  logic clk,
    input  logic reset_n,
    // host ack, marks a new projection
    input  logic angle_start,
    // raw samples from host
    input  logic signed [nabp_pkg::k_sample_length-1:0] hs_sample,
    input  logic hs_sample_valid,
    // filtered samples to swap control
    output logic signed [nabp_pkg::k_filtered_length-1:0] filtered_val,
    output logic filtered_valid
);

    // filtered sample type, also used to widen samples and taps
    typedef logic signed [nabp_pkg::k_filtered_length-1:0] fval_t;
    typedef logic signed [nabp_pkg::k_sample_length-1:0] sample_t;

    // two previous samples of current projection
    sample_t prev_1;
    sample_t prev_2;

    // history as seen by this cycle's sample
    sample_t hist_1;
    sample_t hist_2;
    fval_t tap_sum;

    // a new angle starts with empty history
    assign hist_1 = angle_start ? '0 : prev_1;
    assign hist_2 = angle_start ? '0 : prev_2;

    // weighted sum, oldest to newest
    assign tap_sum = fval_t'(nabp_pkg::k_fir_tap_0) * fval_t'(hist_2)
                   + fval_t'(nabp_pkg::k_fir_tap_1) * fval_t'(hist_1)
                   + fval_t'(nabp_pkg::k_fir_tap_2) * fval_t'(hs_sample);

    // ~~~~~~~~~~~~~~~~~~~~
    // sample history
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (hs_sample_valid)
        begin
            // shift in newest sample
            prev_2 <= hist_1;
            prev_1 <= hs_sample;
        end
        else if (angle_start)
        begin
            // projections are filtered independently
            prev_1 <= '0;
            prev_2 <= '0;
        end
    end

    // registered output, one cycle after the strobe
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            filtered_valid <= 1'b0;
        end
        else
        begin
            filtered_valid <= hs_sample_valid;
        end
    end

    // payload, no reset
    always_ff @(posedge clk)
    begin
        if (hs_sample_valid)
        begin
            filtered_val <= tap_sum;
        end
    end

endmodule

/* tb.f */
source/nabp_pkg.sv
source/projection_fir.sv
source/filtered_ram_swappable.sv
source/filtered_ram_swap_control.sv
source/nabp_filter_stage.sv
+incdir+dv
dv/tb_top.sv
